// File: files.f
common/ic_addr_pkg.sv
common/ic_cache_pkg.sv
common/l2_if.sv
icache/ic_tag_array.sv
icache/ic_data_array.sv
icache/ic_core.sv
logic/l2_bridge.sv
logic/ic_top.sv
dv/ic_checker.sv
dv/ic_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module ic_tb -o ic_sim

out=$(./obj_dir/ic_sim)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS"

// File: dv/ic_tb.sv
// icache testbench: directed fetch tests against a memory model with random latency
`timescale 1ns/1ps

module ic_tb import ic_addr_pkg::*, ic_cache_pkg::*; ();

  localparam int WAIT_LIMIT = 200;  // cycles per wait loop

  // set 6, set 8, then three tags sharing set 3, set 0, set 5
  localparam logic [ADDR_W-1:0] ADDR_A = 32'h0000_1234;
  localparam logic [ADDR_W-1:0] ADDR_B = 32'h0000_2040;
  localparam logic [ADDR_W-1:0] ADDR_C = 32'h0000_0018;
  localparam logic [ADDR_W-1:0] ADDR_D = 32'h0000_0098;
  localparam logic [ADDR_W-1:0] ADDR_E = 32'h0000_0118;
  localparam logic [ADDR_W-1:0] ADDR_F = 32'h0000_4400;
  localparam logic [ADDR_W-1:0] ADDR_G = 32'h0000_5528;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_req_valid;
  logic                o_req_ready;
  logic [ADDR_W-1:0]   i_req_addr;
  logic                o_resp_valid;
  logic [ADDR_W-1:0]   o_resp_addr;
  logic [LINE_W-1:0]   o_resp_data;
  logic                o_miss;
  logic [ADDR_W-1:0]   o_miss_addr;
  logic                o_mem_req_valid;
  logic                i_mem_req_ready;
  logic [ADDR_W-1:0]   o_mem_req_addr;
  logic [L2_TAG_W-1:0] o_mem_req_tag;
  logic                i_mem_resp_valid;
  logic [L2_TAG_W-1:0] i_mem_resp_tag;
  logic [LINE_W-1:0]   i_mem_resp_data;

  logic [15:0]         lfsr_state;
  logic [ADDR_W-1:0]   fetch_q [$];
  int                  errors;
  int                  test_errors;
  int                  tests_run;
  int                  tests_failed;
  string               test_name;

  ic_top dut_i (.*);

  bind ic_top ic_checker chk_i (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .o_req_ready     (o_req_ready),
    .o_resp_valid    (o_resp_valid),
    .o_miss          (o_miss),
    .o_mem_req_valid (o_mem_req_valid),
    .i_mem_req_ready (i_mem_req_ready),
    .o_mem_req_addr  (o_mem_req_addr),
    .o_mem_req_tag   (o_mem_req_tag)
  );

  always #20 i_clk = ~i_clk;  // 40 ns period

  // ============================================================
  // helpers
  // ============================================================
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 16'hB400 : 16'h0000);
    return b;
  endfunction

  function automatic logic [ADDR_W-1:0] line_of(input logic [ADDR_W-1:0] addr);
    return addr & ~ADDR_W'(LINE_B - 1);
  endfunction

  // memory image holds the line address then its inverse
  function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] addr);
    return {line_of(addr), ~line_of(addr)};
  endfunction

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout waiting for %s after %0d cycles", what, WAIT_LIMIT);
    errors++;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_errors) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - test_errors);
    end
  endtask

  task automatic check_resp(input logic [ADDR_W-1:0] exp_addr, input logic [LINE_W-1:0] exp_data);
    if (o_resp_valid !== 1'b1 || o_resp_addr !== exp_addr || o_resp_data !== exp_data) begin
      report_error($sformatf("resp valid %0b addr %h data %h, expected addr %h data %h",
                             o_resp_valid, o_resp_addr, o_resp_data, exp_addr, exp_data));
    end
  endtask

  task automatic check_miss(input logic [ADDR_W-1:0] exp_addr);
    if (o_miss !== 1'b1 || o_miss_addr !== exp_addr) begin
      report_error($sformatf("miss %0b addr %h, expected addr %h", o_miss, o_miss_addr, exp_addr));
    end
  endtask

  task automatic check_mem_req(input logic [ADDR_W-1:0] exp_addr,
                               input logic [L2_TAG_W-1:0] exp_tag);
    if (o_mem_req_valid !== 1'b1 || o_mem_req_addr !== exp_addr || o_mem_req_tag !== exp_tag) begin
      report_error($sformatf("mem req valid %0b addr %h tag %h, expected addr %h tag %h",
                             o_mem_req_valid, o_mem_req_addr, o_mem_req_tag, exp_addr, exp_tag));
    end
  endtask

  // returns on a falling edge with o_req_ready high
  task automatic wait_ready();
    int n;
    n = 0;
    while (!o_req_ready && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_req_ready) report_timeout("o_req_ready");
  endtask

  task automatic send_resp(input logic [L2_TAG_W-1:0] tag, input logic [LINE_W-1:0] data);
    i_mem_resp_valid = 1'b1;
    i_mem_resp_tag   = tag;
    i_mem_resp_data  = data;
    @(negedge i_clk);
    i_mem_resp_valid = 1'b0;
  endtask

  // ============================================================
  // fetch side
  // ============================================================
  task automatic fetch_miss(input logic [ADDR_W-1:0] addr);
    wait_ready();
    i_req_valid = 1'b1;
    i_req_addr  = addr;
    @(negedge i_clk);
    i_req_valid = 1'b0;
    if (o_miss || o_resp_valid) report_error("miss or response 1 cycle after accept");
    @(negedge i_clk);
    check_miss(addr);
    if (o_req_ready) report_error("o_req_ready high after miss");
    @(negedge i_clk);
    if (o_miss) report_error("o_miss held longer than 1 cycle");
  endtask

  // issues fetch_q back to back and expects each to hit 2 cycles later
  task automatic run_hits();
    int n;
    n = fetch_q.size();
    wait_ready();
    for (int k = 0; k < n + 2; k++) begin
      if (k >= 2) begin
        check_resp(fetch_q[k-2], line_data(fetch_q[k-2]));
      end else if (k == 1 && o_resp_valid) begin
        report_error("response 1 cycle after accept");
      end
      if (k < n && !o_req_ready) report_error("o_req_ready dropped during hits");
      if (k < n) begin
        i_req_valid = 1'b1;
        i_req_addr  = fetch_q[k];
      end else begin
        i_req_valid = 1'b0;
      end
      @(negedge i_clk);
    end
    if (o_resp_valid) report_error("response with no fetch behind it");
  endtask

  // ============================================================
  // memory model
  // ============================================================
  task automatic serve_mem(input logic [ADDR_W-1:0] exp_line, input bit bad_first,
                           input int hold);
    int   n;
    int   delay;
    logic rdy;
    n = 0;
    while (!o_mem_req_valid && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_mem_req_valid) begin
      report_timeout("memory request");
      return;
    end
    for (int c = 0; c < hold; c++) begin  // ready held low
      check_mem_req(exp_line, IC_L2_TAG);
      @(negedge i_clk);
    end
    n = 0;
    rdy = 1'b0;
    while (!rdy && n < WAIT_LIMIT) begin
      check_mem_req(exp_line, IC_L2_TAG);
      rdy = lfsr_bit();
      i_mem_req_ready = rdy;
      @(negedge i_clk);
      n++;
    end
    i_mem_req_ready = 1'b0;
    if (!rdy) begin
      report_timeout("memory handshake");
      return;
    end
    delay = 1;
    for (int b = 0; b < 3; b++) begin
      delay += int'(lfsr_bit()) << b;
    end
    for (int c = 0; c < delay; c++) begin
      if (o_mem_req_valid) report_error("memory request issued twice");
      @(negedge i_clk);
    end
    if (bad_first) begin
      send_resp(~IC_L2_TAG, ~line_data(exp_line));  // some other requester
      for (int c = 0; c < 3; c++) begin
        if (o_req_ready) report_error("refill taken from a foreign tag");
        @(negedge i_clk);
      end
    end
    send_resp(IC_L2_TAG, line_data(exp_line));
    n = 0;
    while (!o_req_ready && n < WAIT_LIMIT) begin
      if (o_mem_req_valid) report_error("memory request issued twice");
      @(negedge i_clk);
      n++;
    end
    if (!o_req_ready) report_timeout("o_req_ready after refill");
  endtask

  // ============================================================
  // tests
  // ============================================================
  task automatic test_reset_miss();
    begin_test("reset_miss");
    if (o_req_ready !== 1'b1 || o_mem_req_valid !== 1'b0 || o_resp_valid !== 1'b0 ||
        o_miss !== 1'b0) begin
      report_error("outputs not idle after reset");
    end
    fetch_miss(ADDR_A);
    serve_mem(line_of(ADDR_A), 1'b0, 0);
    end_test();
  endtask

  task automatic test_refill_hit();
    begin_test("refill_hit");
    fetch_q = {ADDR_A};
    run_hits();
    fetch_miss(ADDR_B);
    serve_mem(line_of(ADDR_B), 1'b0, 0);
    fetch_q = {ADDR_A, ADDR_B, 32'h0000_1230, 32'h0000_2046};  // other offsets in the same lines
    run_hits();
    end_test();
  endtask

  task automatic test_same_set();
    begin_test("same_set");
    fetch_miss(ADDR_C);
    serve_mem(line_of(ADDR_C), 1'b0, 0);
    fetch_miss(ADDR_D);
    serve_mem(line_of(ADDR_D), 1'b0, 0);
    fetch_q = {ADDR_C, ADDR_D, ADDR_C};
    run_hits();
    end_test();
  endtask

  task automatic test_evict();
    begin_test("evict");
    fetch_miss(ADDR_E);
    serve_mem(line_of(ADDR_E), 1'b0, 0);
    fetch_q = {ADDR_D, ADDR_E};
    run_hits();
    fetch_miss(ADDR_C);  // oldest line is gone
    serve_mem(line_of(ADDR_C), 1'b0, 0);
    end_test();
  endtask

  task automatic test_bad_tag();
    begin_test("bad_tag");
    fetch_miss(ADDR_F);
    serve_mem(line_of(ADDR_F), 1'b1, 0);
    fetch_q = {ADDR_F};
    run_hits();
    end_test();
  endtask

  task automatic test_backpressure();
    begin_test("backpressure");
    fetch_miss(ADDR_G);
    serve_mem(line_of(ADDR_G), 1'b0, 6);
    fetch_q = {ADDR_G};
    run_hits();
    end_test();
  endtask

  initial begin
    i_clk            = 1'b0;
    i_reset_n        = 1'b0;
    i_req_valid      = 1'b0;
    i_req_addr       = '0;
    i_mem_req_ready  = 1'b0;
    i_mem_resp_valid = 1'b0;
    i_mem_resp_tag   = '0;
    i_mem_resp_data  = '0;
    lfsr_state       = 16'd59308;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    repeat (5) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    test_reset_miss();
    test_refill_hit();
    test_same_set();
    test_evict();
    test_bad_tag();
    test_backpressure();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/ic_checker.sv
// icache protocol checker: memory request stability, response exclusivity, fetch blocking
`timescale 1ns/1ps

module ic_checker import ic_addr_pkg::*, ic_cache_pkg::*; (
  input logic                i_clk,
  input logic                i_reset_n,
  input logic                o_req_ready,
  input logic                o_resp_valid,
  input logic                o_miss,
  input logic                o_mem_req_valid,
  input logic                i_mem_req_ready,
  input logic [ADDR_W-1:0]   o_mem_req_addr,
  input logic [L2_TAG_W-1:0] o_mem_req_tag
);

  // stalled request keeps its payload
  a_mem_req_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_mem_req_valid && !i_mem_req_ready |=>
      o_mem_req_valid && $stable(o_mem_req_addr) && $stable(o_mem_req_tag))
    else $error("memory request changed or dropped while stalled");

  a_resp_miss_excl: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_resp_valid && o_miss))
    else $error("o_resp_valid and o_miss high together");

  // fetches blocked while the refill request is out
  a_ready_blocked: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_mem_req_valid |-> !o_req_ready)
    else $error("o_req_ready high with a memory request outstanding");

endmodule

// File: logic/ic_top.sv
// icache top: core and memory bridge joined by the L2 channels
`timescale 1ns/1ps

module ic_top import ic_addr_pkg::*, ic_cache_pkg::*; (
  input  logic                i_clk,
  input  logic                i_reset_n,
  // fetch side
  input  logic                i_req_valid,
  output logic                o_req_ready,
  input  logic [ADDR_W-1:0]   i_req_addr,
  output logic                o_resp_valid,
  output logic [ADDR_W-1:0]   o_resp_addr,
  output logic [LINE_W-1:0]   o_resp_data,
  output logic                o_miss,
  output logic [ADDR_W-1:0]   o_miss_addr,
  // memory side
  output logic                o_mem_req_valid,
  input  logic                i_mem_req_ready,
  output logic [ADDR_W-1:0]   o_mem_req_addr,
  output logic [L2_TAG_W-1:0] o_mem_req_tag,
  input  logic                i_mem_resp_valid,
  input  logic [L2_TAG_W-1:0] i_mem_resp_tag,
  input  logic [LINE_W-1:0]   i_mem_resp_data
);

  l2_req_if  u_l2_req ();
  l2_resp_if u_l2_resp ();

  ic_core u_core (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req_addr   (i_req_addr),
    .o_resp_valid (o_resp_valid),
    .o_resp_addr  (o_resp_addr),
    .o_resp_data  (o_resp_data),
    .o_miss       (o_miss),
    .o_miss_addr  (o_miss_addr),
    .l2_req       (u_l2_req.master),
    .l2_resp      (u_l2_resp.slave)
  );

  l2_bridge u_bridge (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .l2_req           (u_l2_req.slave),
    .l2_resp          (u_l2_resp.master),
    .o_mem_req_valid  (o_mem_req_valid),
    .i_mem_req_ready  (i_mem_req_ready),
    .o_mem_req_addr   (o_mem_req_addr),
    .o_mem_req_tag    (o_mem_req_tag),
    .i_mem_resp_valid (i_mem_resp_valid),
    .i_mem_resp_tag   (i_mem_resp_tag),
    .i_mem_resp_data  (i_mem_resp_data)
  );

endmodule

// File: logic/l2_bridge.sv
// L2 bridge: one-entry request and response registers toward plain memory ports
`timescale 1ns/1ps

module l2_bridge import ic_addr_pkg::*, ic_cache_pkg::*; (
  input  logic                i_clk,
  input  logic                i_reset_n,
  l2_req_if.slave             l2_req,
  l2_resp_if.master           l2_resp,
  output logic                o_mem_req_valid,
  input  logic                i_mem_req_ready,
  output logic [ADDR_W-1:0]   o_mem_req_addr,
  output logic [L2_TAG_W-1:0] o_mem_req_tag,
  input  logic                i_mem_resp_valid,
  input  logic [L2_TAG_W-1:0] i_mem_resp_tag,
  input  logic [LINE_W-1:0]   i_mem_resp_data
);

  logic                r_req_valid;
  logic [ADDR_W-1:0]   r_req_addr;
  logic [L2_TAG_W-1:0] r_req_tag;
  logic                w_req_take;
  logic                r_resp_valid;
  logic [L2_TAG_W-1:0] r_resp_tag;
  logic [LINE_W-1:0]   r_resp_data;

  assign l2_req.ready = ~r_req_valid;  // full buffer stalls the core
  assign w_req_take   = l2_req.valid & l2_req.ready & (l2_req.cmd == CMD_RD);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_req_valid  <= 1'b0;
      r_resp_valid <= 1'b0;
    end else begin
      if (w_req_take) begin
        r_req_valid <= 1'b1;
      end else if (i_mem_req_ready) begin
        r_req_valid <= 1'b0;
      end
      r_resp_valid <= i_mem_resp_valid | (r_resp_valid & ~l2_resp.ready);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_req_take) begin
      r_req_addr <= l2_req.addr;
      r_req_tag  <= l2_req.tag;
    end
    if (i_mem_resp_valid) begin
      r_resp_tag  <= i_mem_resp_tag;
      r_resp_data <= i_mem_resp_data;
    end
  end

  assign o_mem_req_valid = r_req_valid;
  assign o_mem_req_addr  = r_req_addr;
  assign o_mem_req_tag   = r_req_tag;

  assign l2_resp.valid = r_resp_valid;
  assign l2_resp.tag   = r_resp_tag;
  assign l2_resp.data  = r_resp_data;

endmodule

// File: icache/ic_core.sv
// icache core: S0-S2 lookup pipeline, hit way select and single-miss refill FSM
`timescale 1ns/1ps

module ic_core import ic_addr_pkg::*, ic_cache_pkg::*; (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_req_valid,
  output logic              o_req_ready,
  input  logic [ADDR_W-1:0] i_req_addr,
  output logic              o_resp_valid,
  output logic [ADDR_W-1:0] o_resp_addr,
  output logic [LINE_W-1:0] o_resp_data,
  output logic              o_miss,
  output logic [ADDR_W-1:0] o_miss_addr,
  l2_req_if.master          l2_req,
  l2_resp_if.slave          l2_resp
);

  ic_state_t         r_state;
  logic              w_accept;
  logic              w_refill;
  logic [IDX_W-1:0]  w_tag_idx;
  logic [IDX_W-1:0]  w_data_idx;

  logic              r_s1_valid;
  logic [ADDR_W-1:0] r_s1_addr;
  logic [WAYS-1:0]   w_s1_way_hit;
  logic              w_s1_miss;

  logic              r_s2_valid;
  logic [ADDR_W-1:0] r_s2_addr;
  logic [WAYS-1:0]   r_s2_way_hit;
  logic [LINE_W-1:0] w_s2_data [WAYS];
  logic [LINE_W-1:0] w_s2_sel;

  logic              r_req_valid;
  logic [ADDR_W-1:0] r_miss_addr;
  logic [WAYS-1:0]   r_victim_oh;  // round-robin fill pointer

  assign w_accept = i_req_valid & o_req_ready;
  assign w_refill = (r_state == ST_WAIT) & l2_resp.valid & l2_resp.ready &
                    (l2_resp.tag == IC_L2_TAG);

  // refill owns the array port, lookups are blocked meanwhile
  assign w_tag_idx  = w_refill ? r_miss_addr[TAG_LOW-1:OFFS_W] : i_req_addr[TAG_LOW-1:OFFS_W];
  assign w_data_idx = w_refill ? r_miss_addr[TAG_LOW-1:OFFS_W] : r_s1_addr[TAG_LOW-1:OFFS_W];

  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [TAG_W-1:0] w_tag;
    logic             w_tag_valid;

    ic_tag_array u_tag (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_wr        (w_refill & r_victim_oh[w]),
      .i_addr      (w_tag_idx),
      .i_tag       (r_miss_addr[ADDR_W-1:TAG_LOW]),
      .o_tag       (w_tag),
      .o_tag_valid (w_tag_valid)
    );

    assign w_s1_way_hit[w] = w_tag_valid & (w_tag == r_s1_addr[ADDR_W-1:TAG_LOW]);

    ic_data_array u_data (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_refill & r_victim_oh[w]),
      .i_addr    (w_data_idx),
      .i_data    (l2_resp.data),
      .o_data    (w_s2_data[w])
    );
  end

  // ============================================================
  // S1 / S2 pipeline
  // ============================================================
  assign w_s1_miss = r_s1_valid & ~(|w_s1_way_hit) & (r_state == ST_IDLE);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid   <= 1'b0;
      r_s2_valid   <= 1'b0;
      r_s2_way_hit <= '0;
      o_miss       <= 1'b0;
    end else begin
      r_s1_valid   <= w_accept & ~w_s1_miss;  // fetch behind a miss is dropped
      r_s2_valid   <= r_s1_valid;
      r_s2_way_hit <= w_s1_way_hit;
      o_miss       <= w_s1_miss;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_addr   <= i_req_addr;
    r_s2_addr   <= r_s1_addr;
    o_miss_addr <= r_s1_addr;
    if (w_s1_miss) begin
      r_miss_addr <= r_s1_addr;
    end
  end

  // one-hot OR of the way outputs
  always_comb begin
    w_s2_sel = '0;
    for (int w = 0; w < WAYS; w++) begin
      w_s2_sel |= {LINE_W{r_s2_way_hit[w]}} & w_s2_data[w];
    end
  end

  assign o_resp_valid = r_s2_valid & (|r_s2_way_hit);
  assign o_resp_addr  = r_s2_addr;
  assign o_resp_data  = w_s2_sel;

  // ============================================================
  // miss FSM
  // ============================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= ST_IDLE;
      r_req_valid <= 1'b0;
      r_victim_oh <= {{(WAYS-1){1'b0}}, 1'b1};
    end else begin
      case (r_state)
        ST_IDLE: begin
          if (w_s1_miss) begin
            r_state     <= ST_WAIT;
            r_req_valid <= 1'b1;
          end
        end
        ST_WAIT: begin
          if (r_req_valid & l2_req.ready) begin
            r_req_valid <= 1'b0;  // handed to the bridge
          end
          if (w_refill) begin
            r_state     <= ST_IDLE;
            r_victim_oh <= {r_victim_oh[WAYS-2:0], r_victim_oh[WAYS-1]};
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  assign o_req_ready   = (r_state == ST_IDLE);
  assign l2_req.valid  = r_req_valid;
  assign l2_req.cmd    = CMD_RD;
  assign l2_req.addr   = {r_miss_addr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
  assign l2_req.tag    = IC_L2_TAG;
  assign l2_resp.ready = 1'b1;  // refills always taken

endmodule

// File: icache/ic_data_array.sv
// data array: one way of cache lines, full-line write, registered read
`timescale 1ns/1ps

module ic_data_array import ic_addr_pkg::*, ic_cache_pkg::*; (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_wr,
  input  logic [IDX_W-1:0]  i_addr,
  input  logic [LINE_W-1:0] i_data,
  output logic [LINE_W-1:0] o_data
);

  logic [LINE_W-1:0] r_lines [SETS];

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_lines[i_addr] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_data <= '0;
    end else begin
      o_data <= r_lines[i_addr];  // old data on a same-set write
    end
  end

endmodule

// File: icache/ic_tag_array.sv
// tag array: one way of tags with per-set valid bits, registered read
`timescale 1ns/1ps

module ic_tag_array import ic_addr_pkg::*, ic_cache_pkg::*; (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_wr,
  input  logic [IDX_W-1:0] i_addr,
  input  logic [TAG_W-1:0] i_tag,
  output logic [TAG_W-1:0] o_tag,
  output logic             o_tag_valid
);

  logic [TAG_W-1:0] r_tags [SETS];
  logic [SETS-1:0]  r_valid;

  // valid bits, cleared so a fresh cache misses everywhere
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      o_tag_valid <= 1'b0;
    end else if (i_wr) begin
      r_valid[i_addr] <= 1'b1;
    end else begin
      o_tag_valid <= r_valid[i_addr];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tags[i_addr] <= i_tag;
    end else begin
      o_tag <= r_tags[i_addr];  // no read on a write cycle
    end
  end

endmodule

// File: common/l2_if.sv
// L2 request and response channels, valid/ready with tagged payload
`timescale 1ns/1ps

interface l2_req_if import ic_addr_pkg::*, ic_cache_pkg::*; ();

  logic                valid;
  logic                ready;
  l2_cmd_t             cmd;
  logic [ADDR_W-1:0]   addr;   // line aligned
  logic [L2_TAG_W-1:0] tag;

  modport master (output valid, output cmd, output addr, output tag, input ready);
  modport slave  (input valid, input cmd, input addr, input tag, output ready);

endinterface

interface l2_resp_if import ic_cache_pkg::*; ();

  logic                valid;
  logic                ready;
  logic [L2_TAG_W-1:0] tag;   // echoes the request tag
  logic [LINE_W-1:0]   data;

  modport master (output valid, output tag, output data, input ready);
  modport slave  (input valid, input tag, input data, output ready);

endinterface

// File: common/ic_cache_pkg.sv
// cache package: geometry, L2 command encoding, request tag and miss FSM states
package ic_cache_pkg;

  // ============================================================
  // geometry
  // ============================================================
  localparam int WAYS   = 2;
  localparam int SETS   = 1 << ic_addr_pkg::IDX_W;
  localparam int LINE_W = ic_addr_pkg::LINE_B * 8;  // one line per refill beat

  // ============================================================
  // L2 channel
  // ============================================================
  localparam int L2_TAG_W = 4;

  // requester id, top bit marks the instruction cache
  localparam logic [L2_TAG_W-1:0] IC_L2_TAG = {1'b1, {(L2_TAG_W-1){1'b0}}};

  typedef enum logic [1:0] {
    CMD_RD = 2'd0,
    CMD_WR = 2'd1
  } l2_cmd_t;

  // miss handling
  typedef enum logic {
    ST_IDLE = 1'b0,  // lookups flowing
    ST_WAIT = 1'b1   // refill outstanding, fetches blocked
  } ic_state_t;

endpackage

// File: common/ic_addr_pkg.sv
// address package: fetch address width and line, index and tag field positions
package ic_addr_pkg;

  localparam int ADDR_W  = 32;              // physical fetch address
  localparam int LINE_B  = 8;               // bytes per line
  localparam int OFFS_W  = $clog2(LINE_B);  // byte offset in a line
  localparam int IDX_W   = 4;               // set index bits

  // address layout, msb to lsb
  //   [ADDR_W-1:TAG_LOW]   tag
  //   [TAG_LOW-1:OFFS_W]   set index
  //   [OFFS_W-1:0]         byte offset
  localparam int TAG_LOW = OFFS_W + IDX_W;
  localparam int TAG_W   = ADDR_W - TAG_LOW;

endpackage
